// ==== Bender.yml ====
package:
  name: ixu

sources:
  - files:
      - source/ixu_pkg.sv
      - source/ixu_iram.sv
      - source/ixu_alu.sv
      - source/ixu_wb_merge.sv
      - source/ixu_top.sv
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/tb_ixu_checker.sv
      - bench/tb_ixu.sv

// ==== bench/tb_clock_gen.sv ====
// Testbench clock and reset

module tb_clock_gen (
  output logic cpu_clk_o,
  output logic reset_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // 4 ns period
  initial begin
    cpu_clk_o = 1'b0;
    forever #2 cpu_clk_o = ~cpu_clk_o;
  end

  // Reset covers the first two rising edges
  initial begin
    reset_o = 1'b1;
    repeat (2) @(posedge cpu_clk_o);
    reset_o <= 1'b0;
  end

endmodule

// ==== bench/tb_ixu.sv ====
// Integer execution cluster testbench

module tb_ixu;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned SEED = 32'h602b_0b32;
  localparam int MIX_CYCLES = 2000;
  // Fill and single issue 96, bank select 32, ALU ops 160, dual 32, overwrite 16
  localparam int DIRECTED_TXNS = 96 + 32 + 160 + 32 + 16;
  localparam int PLANNED_TXNS = DIRECTED_TXNS + MIX_CYCLES;
  localparam int TIMEOUT_NS = 40 * PLANNED_TXNS + 200;

  logic               cpu_clk;
  logic               reset;
  logic               ins0_valid;
  ixu_pkg::ins_type_t ins0_ins_type;
  logic               ins0_imm;
  ixu_pkg::imm_t      ins0_immediate;
  ixu_pkg::phys_reg_t ins0_dest;
  ixu_pkg::hint_t     ins0_hint;
  logic               ins1_valid;
  ixu_pkg::ins_type_t ins1_ins_type;
  logic               ins1_imm;
  ixu_pkg::imm_t      ins1_immediate;
  ixu_pkg::phys_reg_t ins1_dest;
  ixu_pkg::hint_t     ins1_hint;
  ixu_pkg::pack_id_t  pack_id;
  logic               issue0_valid;
  ixu_pkg::rob_id_t   issue0_rob;
  ixu_pkg::xlen_t     issue0_rs1;
  ixu_pkg::xlen_t     issue0_rs2;
  logic               issue1_valid;
  ixu_pkg::rob_id_t   issue1_rob;
  ixu_pkg::xlen_t     issue1_rs1;
  ixu_pkg::xlen_t     issue1_rs2;
  logic               wb_valid;
  ixu_pkg::xlen_t     wb_data;
  ixu_pkg::phys_reg_t wb_dest;
  ixu_pkg::rob_id_t   wb_rob;
  ixu_pkg::hint_t     wb_hint;
  logic               stall;

  // Next payload and operands per lane, consumed by drive_cycle
  ixu_pkg::ins_type_t nxt_type [2];
  logic               nxt_imm  [2];
  ixu_pkg::imm_t      nxt_immd [2];
  ixu_pkg::phys_reg_t nxt_dest [2];
  ixu_pkg::hint_t     nxt_hint [2];
  ixu_pkg::xlen_t     nxt_rs1  [2];
  ixu_pkg::xlen_t     nxt_rs2  [2];

  // Model of both payload banks
  ixu_pkg::ins_type_t m_type [2][ixu_pkg::PACK_DEPTH];
  logic               m_imm  [2][ixu_pkg::PACK_DEPTH];
  ixu_pkg::imm_t      m_immd [2][ixu_pkg::PACK_DEPTH];
  ixu_pkg::phys_reg_t m_dest [2][ixu_pkg::PACK_DEPTH];
  ixu_pkg::hint_t     m_hint [2][ixu_pkg::PACK_DEPTH];

  string       test_name = "reset";
  logic        dual_prev;
  int unsigned seed = SEED;

  tb_clock_gen i_clock_gen (
    .cpu_clk_o (cpu_clk),
    .reset_o   (reset)
  );

  ixu_top i_dut (
    .cpu_clk_i        (cpu_clk),
    .reset_i          (reset),
    .ins0_valid_i     (ins0_valid),
    .ins0_ins_type_i  (ins0_ins_type),
    .ins0_imm_i       (ins0_imm),
    .ins0_immediate_i (ins0_immediate),
    .ins0_dest_i      (ins0_dest),
    .ins0_hint_i      (ins0_hint),
    .ins1_valid_i     (ins1_valid),
    .ins1_ins_type_i  (ins1_ins_type),
    .ins1_imm_i       (ins1_imm),
    .ins1_immediate_i (ins1_immediate),
    .ins1_dest_i      (ins1_dest),
    .ins1_hint_i      (ins1_hint),
    .pack_id_i        (pack_id),
    .issue0_valid_i   (issue0_valid),
    .issue0_rob_i     (issue0_rob),
    .issue0_rs1_i     (issue0_rs1),
    .issue0_rs2_i     (issue0_rs2),
    .issue1_valid_i   (issue1_valid),
    .issue1_rob_i     (issue1_rob),
    .issue1_rs1_i     (issue1_rs1),
    .issue1_rs2_i     (issue1_rs2),
    .wb_valid_o       (wb_valid),
    .wb_data_o        (wb_data),
    .wb_dest_o        (wb_dest),
    .wb_rob_o         (wb_rob),
    .wb_hint_o        (wb_hint),
    .stall_o          (stall)
  );

  tb_ixu_checker i_checker (
    .cpu_clk_i      (cpu_clk),
    .reset_i        (reset),
    .issue0_valid_i (issue0_valid),
    .issue1_valid_i (issue1_valid),
    .wb_valid_i     (wb_valid),
    .wb_data_i      (wb_data),
    .wb_dest_i      (wb_dest),
    .wb_rob_i       (wb_rob),
    .wb_hint_i      (wb_hint),
    .stall_i        (stall)
  );

  // Reference ALU where SLT compares the signs first and the magnitudes after
  function automatic ixu_pkg::xlen_t alu_model(input ixu_pkg::alu_op_t op,
                                               input ixu_pkg::xlen_t a,
                                               input ixu_pkg::xlen_t b);
    int unsigned sh;
    sh = b % 32;
    case (op)
      ixu_pkg::OP_ADD: return a + b;
      ixu_pkg::OP_SUB: return a + ~b + 32'd1;
      ixu_pkg::OP_AND: return a & b;
      ixu_pkg::OP_OR:  return a | b;
      ixu_pkg::OP_XOR: return a ^ b;
      ixu_pkg::OP_SLL: return a << sh;
      ixu_pkg::OP_SRL: return a >> sh;
      default: begin
        if (a[31] != b[31]) begin
          return {31'd0, a[31]};
        end
        return {31'd0, a < b};
      end
    endcase
  endfunction

  function automatic ixu_pkg::rob_id_t rand_rob();
    logic [31:0] r;
    r = $urandom();
    return r[4:0];
  endfunction

  task automatic randomize_stimulus();
    logic [31:0] r;
    for (int l = 0; l < 2; l++) begin
      r = $urandom();
      nxt_type[l] = r[5:0];
      nxt_imm[l]  = r[6];
      nxt_hint[l] = r[8:7];
      nxt_dest[l] = r[14:9];
      nxt_immd[l] = $urandom();
      nxt_rs1[l]  = $urandom();
      nxt_rs2[l]  = $urandom();
    end
  endtask

  task automatic store_model(input int lane, input ixu_pkg::pack_id_t pid);
    m_type[lane][pid] = nxt_type[lane];
    m_imm[lane][pid]  = nxt_imm[lane];
    m_immd[lane][pid] = nxt_immd[lane];
    m_dest[lane][pid] = nxt_dest[lane];
    m_hint[lane][pid] = nxt_hint[lane];
  endtask

  task automatic push_expect(input ixu_pkg::rob_id_t rob, input ixu_pkg::xlen_t rs1,
                             input ixu_pkg::xlen_t rs2, input int unsigned delay);
    ixu_pkg::xlen_t    b;
    ixu_pkg::xlen_t    data;
    logic              bank;
    ixu_pkg::pack_id_t entry;
    bank  = rob[0];
    entry = rob[4:1];
    b     = m_imm[bank][entry] ? m_immd[bank][entry] : rs2;
    data  = alu_model(m_type[bank][entry][2:0], rs1, b);
    i_checker.expect_wb(test_name, data, m_dest[bank][entry], rob, m_hint[bank][entry], delay);
  endtask

  // One clock of dispatch and issue on both lanes
  task automatic drive_cycle(input logic d0, input logic d1, input ixu_pkg::pack_id_t pid,
                             input logic i0, input ixu_pkg::rob_id_t r0,
                             input logic i1, input ixu_pkg::rob_id_t r1);
    // After a dual issue the stall covers the very next cycle, so that slot stays empty
    if (dual_prev && (i0 || i1)) begin
      @(posedge cpu_clk);
      ins0_valid   <= 1'b0;
      ins1_valid   <= 1'b0;
      issue0_valid <= 1'b0;
      issue1_valid <= 1'b0;
    end
    @(posedge cpu_clk);
    ins0_valid     <= d0;
    ins0_ins_type  <= nxt_type[0];
    ins0_imm       <= nxt_imm[0];
    ins0_immediate <= nxt_immd[0];
    ins0_dest      <= nxt_dest[0];
    ins0_hint      <= nxt_hint[0];
    ins1_valid     <= d1;
    ins1_ins_type  <= nxt_type[1];
    ins1_imm       <= nxt_imm[1];
    ins1_immediate <= nxt_immd[1];
    ins1_dest      <= nxt_dest[1];
    ins1_hint      <= nxt_hint[1];
    pack_id        <= pid;
    issue0_valid   <= i0;
    issue0_rob     <= r0;
    issue0_rs1     <= nxt_rs1[0];
    issue0_rs2     <= nxt_rs2[0];
    issue1_valid   <= i1;
    issue1_rob     <= r1;
    issue1_rs1     <= nxt_rs1[1];
    issue1_rs2     <= nxt_rs2[1];
    // Issue reads the banks before a dispatch on the same edge lands
    if (i0) begin
      push_expect(r0, nxt_rs1[0], nxt_rs2[0], 1);
    end
    if (i1) begin
      push_expect(r1, nxt_rs1[1], nxt_rs2[1], i0 ? 2 : 1);
    end
    if (d0) begin
      store_model(0, pid);
    end
    if (d1) begin
      store_model(1, pid);
    end
    dual_prev = i0 && i1;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_cycle(1'b0, 1'b0, '0, 1'b0, '0, 1'b0, '0);
  endtask

  task automatic fill_and_issue_singly();
    logic [31:0] r;
    test_name = "single_issue";
    for (int p = 0; p < ixu_pkg::PACK_DEPTH; p++) begin
      randomize_stimulus();
      drive_cycle(1'b1, 1'b1, p[3:0], 1'b0, '0, 1'b0, '0);
    end
    // Second pass with packs where only one lane is valid
    for (int p = 0; p < ixu_pkg::PACK_DEPTH; p++) begin
      r = $urandom();
      randomize_stimulus();
      drive_cycle(r[0], !r[0] || r[1], p[3:0], 1'b0, '0, 1'b0, '0);
    end
    for (int lane = 0; lane < 2; lane++) begin
      for (int rob = 0; rob < 32; rob++) begin
        randomize_stimulus();
        drive_cycle(1'b0, 1'b0, '0, lane == 0, rob[4:0], lane == 1, rob[4:0]);
      end
    end
    idle_cycles(3);
  endtask

  task automatic select_banks();
    test_name = "bank_select";
    for (int p = 0; p < ixu_pkg::PACK_DEPTH; p++) begin
      randomize_stimulus();
      drive_cycle(1'b0, 1'b0, '0, 1'b1, {p[3:0], 1'b0}, 1'b1, {p[3:0], 1'b1});
      // Same entry on both read ports
      randomize_stimulus();
      drive_cycle(1'b0, 1'b0, '0, 1'b1, {p[3:0], p[0]}, 1'b1, {p[3:0], p[0]});
    end
    idle_cycles(3);
  endtask

  task automatic sweep_alu_ops();
    ixu_pkg::pack_id_t pid;
    ixu_pkg::xlen_t    b_val;
    test_name = "alu_ops";
    for (int op = 0; op < 8; op++) begin
      for (int imm = 0; imm < 2; imm++) begin
        for (int k = 0; k < 5; k++) begin
          randomize_stimulus();
          b_val = $urandom();
          case (k)
            0: b_val = 32'd31;
            // Shift amounts past 31 wrap on the low five bits
            1: b_val = 32'd32;
            2: begin
              b_val      = 32'd63;
              nxt_rs1[0] = 32'h8000_0000;
            end
            // Small positive against minus one tells signed from unsigned compare
            3: begin
              b_val      = 32'hFFFF_FFFF;
              nxt_rs1[0] = 32'd1;
            end
            default: ;
          endcase
          pid              = {op[2:0], imm[0]};
          nxt_type[0][2:0] = op[2:0];
          nxt_imm[0]       = imm[0];
          if (imm[0]) begin
            nxt_immd[0] = b_val;
          end else begin
            nxt_rs2[0] = b_val;
          end
          drive_cycle(1'b1, 1'b0, pid, 1'b0, '0, 1'b0, '0);
          drive_cycle(1'b0, 1'b0, '0, 1'b1, {pid, 1'b0}, 1'b0, '0);
        end
      end
    end
    idle_cycles(3);
  endtask

  task automatic issue_dual_pairs();
    test_name = "dual_issue";
    for (int n = 0; n < 16; n++) begin
      randomize_stimulus();
      drive_cycle(1'b0, 1'b0, '0, 1'b1, rand_rob(), 1'b1, rand_rob());
      // Asked for straight away but lands only once the stall cycle has passed
      randomize_stimulus();
      drive_cycle(1'b0, 1'b0, '0, 1'b1, rand_rob(), 1'b0, '0);
    end
    idle_cycles(3);
  endtask

  task automatic overwrite_one_lane();
    ixu_pkg::pack_id_t pid;
    test_name = "overwrite";
    for (int n = 0; n < 8; n++) begin
      pid = ixu_pkg::pack_id_t'($urandom());
      randomize_stimulus();
      drive_cycle(n[0] == 1'b0, n[0] == 1'b1, pid, 1'b0, '0, 1'b0, '0);
      randomize_stimulus();
      drive_cycle(1'b0, 1'b0, '0, 1'b1, {pid, 1'b0}, 1'b1, {pid, 1'b1});
    end
    idle_cycles(3);
  endtask

  task automatic random_mix();
    logic [31:0] r;
    test_name = "random_mix";
    for (int n = 0; n < MIX_CYCLES; n++) begin
      r = $urandom();
      randomize_stimulus();
      drive_cycle(r[0], r[1], r[5:2], r[6], rand_rob(), r[7], rand_rob());
    end
    idle_cycles(4);
  endtask

  initial begin
    ins0_valid     = 1'b0;
    ins0_ins_type  = '0;
    ins0_imm       = 1'b0;
    ins0_immediate = '0;
    ins0_dest      = '0;
    ins0_hint      = '0;
    ins1_valid     = 1'b0;
    ins1_ins_type  = '0;
    ins1_imm       = 1'b0;
    ins1_immediate = '0;
    ins1_dest      = '0;
    ins1_hint      = '0;
    pack_id        = '0;
    issue0_valid   = 1'b0;
    issue0_rob     = '0;
    issue0_rs1     = '0;
    issue0_rs2     = '0;
    issue1_valid   = 1'b0;
    issue1_rob     = '0;
    issue1_rs1     = '0;
    issue1_rs2     = '0;
    dual_prev      = 1'b0;
    void'($urandom(seed));
    wait (reset === 1'b0);
    fill_and_issue_singly();
    select_banks();
    sweep_alu_ops();
    issue_dual_pairs();
    overwrite_one_lane();
    random_mix();
    i_checker.report_summary();
    if (i_checker.error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog sized from the planned transaction count
  initial begin
    #(TIMEOUT_NS);
    $display("Run timed out after %0d ns in %s", TIMEOUT_NS, test_name);
    $display("Errors found");
    $finish;
  end

endmodule

// ==== bench/tb_ixu_checker.sv ====
// Writeback checker for the execution cluster

module tb_ixu_checker (
  input logic                 cpu_clk_i,
  input logic                 reset_i,
  input logic                 issue0_valid_i,
  input logic                 issue1_valid_i,
  input logic                 wb_valid_i,
  input ixu_pkg::xlen_t       wb_data_i,
  input ixu_pkg::phys_reg_t   wb_dest_i,
  input ixu_pkg::rob_id_t     wb_rob_i,
  input ixu_pkg::hint_t       wb_hint_i,
  input logic                 stall_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Expected writebacks in the order the port must produce them
  string              name_q [$];
  ixu_pkg::xlen_t     data_q [$];
  ixu_pkg::phys_reg_t dest_q [$];
  ixu_pkg::rob_id_t   rob_q  [$];
  ixu_pkg::hint_t     hint_q [$];
  int unsigned        due_q  [$];

  string       cur_test = "reset";
  int unsigned cycle_cnt = 0;
  int          error_count = 0;
  int          check_count = 0;
  // Set when both lanes were issued in the previous cycle
  logic        dual_q;

  // Called by the bench in the issue cycle, delay counts cycles from issue to writeback
  task automatic expect_wb(input string test, input ixu_pkg::xlen_t data,
                           input ixu_pkg::phys_reg_t dest, input ixu_pkg::rob_id_t rob,
                           input ixu_pkg::hint_t hint, input int unsigned delay);
    cur_test = test;
    name_q.push_back(test);
    data_q.push_back(data);
    dest_q.push_back(dest);
    rob_q.push_back(rob);
    hint_q.push_back(hint);
    due_q.push_back(cycle_cnt + 1 + delay);
  endtask

  task automatic compare_field(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      error_count++;
      $display("MISMATCH %s %s expected 0x%0h actual 0x%0h", test, field, expected, actual);
    end
  endtask

  // Leftover entries are results that never reached the register file
  task automatic report_summary();
    if (data_q.size() != 0) begin
      error_count += data_q.size();
      $display("%0d expected writebacks never arrived, first rob %0d",
               data_q.size(), rob_q[0]);
    end
    $display("Checked %0d writebacks, %0d errors", check_count, error_count);
  endtask

  always @(posedge cpu_clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (reset_i) begin
      dual_q <= 1'b0;
    end else begin
      dual_q <= issue0_valid_i & issue1_valid_i;
    end
  end

  // Mid-cycle sampling, all DUT outputs have settled by now
  always @(negedge cpu_clk_i) begin
    if (reset_i === 1'b0) begin
      // Stall is exactly the cycle after a dual issue
      compare_field(cur_test, "stall", 32'(dual_q), 32'(stall_i));
      if (stall_i === 1'b1 && (issue0_valid_i || issue1_valid_i)) begin
        error_count++;
        $display("An issue was driven during a stall cycle in %s", cur_test);
      end
      if ($isunknown(wb_valid_i)) begin
        error_count++;
        $display("Writeback valid is unknown in %s", cur_test);
      end else if (wb_valid_i) begin
        if (data_q.size() == 0) begin
          error_count++;
          $display("Writeback for rob %0d arrived while no result was expected", wb_rob_i);
        end else begin
          check_count++;
          compare_field(name_q[0], "data", data_q[0], wb_data_i);
          compare_field(name_q[0], "dest", 32'(dest_q[0]), 32'(wb_dest_i));
          compare_field(name_q[0], "rob", 32'(rob_q[0]), 32'(wb_rob_i));
          compare_field(name_q[0], "hint", 32'(hint_q[0]), 32'(wb_hint_i));
          compare_field(name_q[0], "cycle", due_q[0], cycle_cnt);
          void'(name_q.pop_front());
          void'(data_q.pop_front());
          void'(dest_q.pop_front());
          void'(rob_q.pop_front());
          void'(hint_q.pop_front());
          void'(due_q.pop_front());
        end
      end
    end
  end

endmodule

// ==== ixu.f ====
source/ixu_pkg.sv
source/ixu_iram.sv
source/ixu_alu.sv
source/ixu_wb_merge.sv
source/ixu_top.sv
bench/tb_clock_gen.sv
bench/tb_ixu_checker.sv
bench/tb_ixu.sv

// ==== source/ixu_alu.sv ====
// Single integer ALU lane

module ixu_alu (
  input  logic                 cpu_clk_i,
  input  logic                 reset_i,
  // Issue strobe and operands from the issuer
  input  logic                 issue_valid_i,
  input  ixu_pkg::rob_id_t     issue_rob_i,
  input  ixu_pkg::xlen_t       rs1_data_i,
  input  ixu_pkg::xlen_t       rs2_data_i,
  // Payload read from the RAM in the same cycle
  input  ixu_pkg::ins_type_t   ins_type_i,
  input  logic                 imm_i,
  input  ixu_pkg::imm_t        immediate_i,
  input  ixu_pkg::phys_reg_t   dest_i,
  input  ixu_pkg::hint_t       hint_i,
  // Registered result bundle
  output logic                 res_valid_o,
  output ixu_pkg::xlen_t       res_data_o,
  output ixu_pkg::phys_reg_t   res_dest_o,
  output ixu_pkg::rob_id_t     res_rob_o,
  output ixu_pkg::hint_t       res_hint_o
);

  ixu_pkg::alu_op_t alu_op;
  ixu_pkg::xlen_t   op_a;
  ixu_pkg::xlen_t   op_b;
  ixu_pkg::xlen_t   alu_result;
  logic [ixu_pkg::SHAMT_W-1:0] shamt;

  // Operation lives in the low bits of the type field
  assign alu_op = ins_type_i[2:0];

  // Second operand is the immediate for I-type forms
  assign op_a  = rs1_data_i;
  assign op_b  = imm_i ? immediate_i : rs2_data_i;
  assign shamt = op_b[ixu_pkg::SHAMT_W-1:0];

  always_comb begin
    case (alu_op)
      ixu_pkg::OP_ADD: alu_result = op_a + op_b;
      ixu_pkg::OP_SUB: alu_result = op_a - op_b;
      ixu_pkg::OP_AND: alu_result = op_a & op_b;
      ixu_pkg::OP_OR:  alu_result = op_a | op_b;
      ixu_pkg::OP_XOR: alu_result = op_a ^ op_b;
      ixu_pkg::OP_SLL: alu_result = op_a << shamt;
      ixu_pkg::OP_SRL: alu_result = op_a >> shamt;
      // Signed compare, zero extended to a full word
      ixu_pkg::OP_SLT: alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
      default:         alu_result = '0;
    endcase
  end

  // Valid pulses for one cycle, one cycle after the issue strobe
  always_ff @(posedge cpu_clk_i) begin
    if (reset_i) begin
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= issue_valid_i;
    end
  end

  // Payload only loads on a real issue and holds otherwise
  always_ff @(posedge cpu_clk_i) begin
    if (issue_valid_i) begin
      res_data_o <= alu_result;
      res_dest_o <= dest_i;
      res_rob_o  <= issue_rob_i;
      res_hint_o <= hint_i;
    end
  end

  // An unknown rob id would read an undefined RAM entry and poison the result
  // that the merger sends to the register file one cycle later
  a_issue_rob_known : assert property (
    @(posedge cpu_clk_i) disable iff (reset_i)
    issue_valid_i |-> !$isunknown(issue_rob_i)
  );

endmodule

// ==== source/ixu_iram.sv ====
// Dual-bank instruction payload RAM

module ixu_iram (
  input  logic                 cpu_clk_i,
  // Dispatch lane 0
  input  logic                 ins0_valid_i,
  input  ixu_pkg::ins_type_t   ins0_ins_type_i,
  input  logic                 ins0_imm_i,
  input  ixu_pkg::imm_t        ins0_immediate_i,
  input  ixu_pkg::phys_reg_t   ins0_dest_i,
  input  ixu_pkg::hint_t       ins0_hint_i,
  // Dispatch lane 1
  input  logic                 ins1_valid_i,
  input  ixu_pkg::ins_type_t   ins1_ins_type_i,
  input  logic                 ins1_imm_i,
  input  ixu_pkg::imm_t        ins1_immediate_i,
  input  ixu_pkg::phys_reg_t   ins1_dest_i,
  input  ixu_pkg::hint_t       ins1_hint_i,
  // Shared pack index for both dispatch lanes
  input  ixu_pkg::pack_id_t    pack_id_i,
  // Issue read addresses
  input  ixu_pkg::rob_id_t     alu0_rob_i,
  input  ixu_pkg::rob_id_t     alu1_rob_i,
  // Read port 0
  output ixu_pkg::ins_type_t   alu0_ins_type_o,
  output logic                 alu0_imm_o,
  output ixu_pkg::imm_t        alu0_immediate_o,
  output ixu_pkg::phys_reg_t   alu0_dest_o,
  output ixu_pkg::hint_t       alu0_hint_o,
  // Read port 1
  output ixu_pkg::ins_type_t   alu1_ins_type_o,
  output logic                 alu1_imm_o,
  output ixu_pkg::imm_t        alu1_immediate_o,
  output ixu_pkg::phys_reg_t   alu1_dest_o,
  output ixu_pkg::hint_t       alu1_hint_o
);

  // One array per field, first index is the bank and matches the dispatch lane
  ixu_pkg::ins_type_t type_mem [2][ixu_pkg::PACK_DEPTH];
  logic               imm_mem  [2][ixu_pkg::PACK_DEPTH];
  ixu_pkg::imm_t      immd_mem [2][ixu_pkg::PACK_DEPTH];
  ixu_pkg::phys_reg_t dest_mem [2][ixu_pkg::PACK_DEPTH];
  ixu_pkg::hint_t     hint_mem [2][ixu_pkg::PACK_DEPTH];

  // Split each rob id into the bank (slot bit) and the entry (pack id)
  logic              alu0_bank;
  logic              alu1_bank;
  ixu_pkg::pack_id_t alu0_entry;
  ixu_pkg::pack_id_t alu1_entry;

  assign alu0_bank  = alu0_rob_i[0];
  assign alu0_entry = alu0_rob_i[4:1];
  assign alu1_bank  = alu1_rob_i[0];
  assign alu1_entry = alu1_rob_i[4:1];

  // Each dispatch lane owns its bank, so both can write in the same cycle
  always_ff @(posedge cpu_clk_i) begin
    if (ins0_valid_i) begin
      type_mem[0][pack_id_i] <= ins0_ins_type_i;
      imm_mem[0][pack_id_i]  <= ins0_imm_i;
      immd_mem[0][pack_id_i] <= ins0_immediate_i;
      dest_mem[0][pack_id_i] <= ins0_dest_i;
      hint_mem[0][pack_id_i] <= ins0_hint_i;
    end
    if (ins1_valid_i) begin
      type_mem[1][pack_id_i] <= ins1_ins_type_i;
      imm_mem[1][pack_id_i]  <= ins1_imm_i;
      immd_mem[1][pack_id_i] <= ins1_immediate_i;
      dest_mem[1][pack_id_i] <= ins1_dest_i;
      hint_mem[1][pack_id_i] <= ins1_hint_i;
    end
  end

  // Asynchronous reads so the ALU sees the payload in the issue cycle
  assign alu0_ins_type_o  = type_mem[alu0_bank][alu0_entry];
  assign alu0_imm_o       = imm_mem[alu0_bank][alu0_entry];
  assign alu0_immediate_o = immd_mem[alu0_bank][alu0_entry];
  assign alu0_dest_o      = dest_mem[alu0_bank][alu0_entry];
  assign alu0_hint_o      = hint_mem[alu0_bank][alu0_entry];

  assign alu1_ins_type_o  = type_mem[alu1_bank][alu1_entry];
  assign alu1_imm_o       = imm_mem[alu1_bank][alu1_entry];
  assign alu1_immediate_o = immd_mem[alu1_bank][alu1_entry];
  assign alu1_dest_o      = dest_mem[alu1_bank][alu1_entry];
  assign alu1_hint_o      = hint_mem[alu1_bank][alu1_entry];

endmodule

// ==== source/ixu_pkg.sv ====
// Integer execution cluster package

package ixu_pkg;

  // Number of instruction packs held in each payload bank
  localparam int PACK_DEPTH = 16;

  // Shift amounts only ever use this many low bits of the second operand
  localparam int SHAMT_W = 5;

  // Index of a pack in the payload RAM
  typedef logic [3:0] pack_id_t;

  // Reorder-buffer id, the pack id sits above the lane slot in bit 0
  typedef logic [4:0] rob_id_t;

  // Physical destination register number
  typedef logic [5:0] phys_reg_t;

  // Instruction type field
  // Only the low three bits carry the ALU operation, the rest are reserved
  typedef logic [5:0] ins_type_t;

  // Immediate and data word
  typedef logic [31:0] imm_t;
  typedef logic [31:0] xlen_t;

  // Hint that travels alongside the result back to writeback
  typedef logic [1:0] hint_t;

  // ALU operation code
  typedef logic [2:0] alu_op_t;

  localparam alu_op_t OP_ADD = 3'd0;
  localparam alu_op_t OP_SUB = 3'd1;
  localparam alu_op_t OP_AND = 3'd2;
  localparam alu_op_t OP_OR  = 3'd3;
  localparam alu_op_t OP_XOR = 3'd4;
  // Logical shifts by the low SHAMT_W bits of the second operand
  localparam alu_op_t OP_SLL = 3'd5;
  localparam alu_op_t OP_SRL = 3'd6;
  // Signed less-than, result is 1 or 0
  localparam alu_op_t OP_SLT = 3'd7;

endpackage

// ==== source/ixu_top.sv ====
// Integer execution cluster top

module ixu_top (
  input  logic                 cpu_clk_i,
  input  logic                 reset_i,
  // Dispatch lane 0
  input  logic                 ins0_valid_i,
  input  ixu_pkg::ins_type_t   ins0_ins_type_i,
  input  logic                 ins0_imm_i,
  input  ixu_pkg::imm_t        ins0_immediate_i,
  input  ixu_pkg::phys_reg_t   ins0_dest_i,
  input  ixu_pkg::hint_t       ins0_hint_i,
  // Dispatch lane 1
  input  logic                 ins1_valid_i,
  input  ixu_pkg::ins_type_t   ins1_ins_type_i,
  input  logic                 ins1_imm_i,
  input  ixu_pkg::imm_t        ins1_immediate_i,
  input  ixu_pkg::phys_reg_t   ins1_dest_i,
  input  ixu_pkg::hint_t       ins1_hint_i,
  input  ixu_pkg::pack_id_t    pack_id_i,
  // Issue lane 0
  input  logic                 issue0_valid_i,
  input  ixu_pkg::rob_id_t     issue0_rob_i,
  input  ixu_pkg::xlen_t       issue0_rs1_i,
  input  ixu_pkg::xlen_t       issue0_rs2_i,
  // Issue lane 1
  input  logic                 issue1_valid_i,
  input  ixu_pkg::rob_id_t     issue1_rob_i,
  input  ixu_pkg::xlen_t       issue1_rs1_i,
  input  ixu_pkg::xlen_t       issue1_rs2_i,
  // Writeback port and back-pressure to the issuer
  output logic                 wb_valid_o,
  output ixu_pkg::xlen_t       wb_data_o,
  output ixu_pkg::phys_reg_t   wb_dest_o,
  output ixu_pkg::rob_id_t     wb_rob_o,
  output ixu_pkg::hint_t       wb_hint_o,
  output logic                 stall_o
);

  // Payload from the RAM into each lane
  ixu_pkg::ins_type_t alu0_ins_type;
  logic               alu0_imm;
  ixu_pkg::imm_t      alu0_immediate;
  ixu_pkg::phys_reg_t alu0_dest;
  ixu_pkg::hint_t     alu0_hint;
  ixu_pkg::ins_type_t alu1_ins_type;
  logic               alu1_imm;
  ixu_pkg::imm_t      alu1_immediate;
  ixu_pkg::phys_reg_t alu1_dest;
  ixu_pkg::hint_t     alu1_hint;

  // Lane results into the merger
  logic               res0_valid;
  ixu_pkg::xlen_t     res0_data;
  ixu_pkg::phys_reg_t res0_dest;
  ixu_pkg::rob_id_t   res0_rob;
  ixu_pkg::hint_t     res0_hint;
  logic               res1_valid;
  ixu_pkg::xlen_t     res1_data;
  ixu_pkg::phys_reg_t res1_dest;
  ixu_pkg::rob_id_t   res1_rob;
  ixu_pkg::hint_t     res1_hint;

  ixu_iram i_iram (
    .cpu_clk_i        (cpu_clk_i),
    .ins0_valid_i     (ins0_valid_i),
    .ins0_ins_type_i  (ins0_ins_type_i),
    .ins0_imm_i       (ins0_imm_i),
    .ins0_immediate_i (ins0_immediate_i),
    .ins0_dest_i      (ins0_dest_i),
    .ins0_hint_i      (ins0_hint_i),
    .ins1_valid_i     (ins1_valid_i),
    .ins1_ins_type_i  (ins1_ins_type_i),
    .ins1_imm_i       (ins1_imm_i),
    .ins1_immediate_i (ins1_immediate_i),
    .ins1_dest_i      (ins1_dest_i),
    .ins1_hint_i      (ins1_hint_i),
    .pack_id_i        (pack_id_i),
    .alu0_rob_i       (issue0_rob_i),
    .alu1_rob_i       (issue1_rob_i),
    .alu0_ins_type_o  (alu0_ins_type),
    .alu0_imm_o       (alu0_imm),
    .alu0_immediate_o (alu0_immediate),
    .alu0_dest_o      (alu0_dest),
    .alu0_hint_o      (alu0_hint),
    .alu1_ins_type_o  (alu1_ins_type),
    .alu1_imm_o       (alu1_imm),
    .alu1_immediate_o (alu1_immediate),
    .alu1_dest_o      (alu1_dest),
    .alu1_hint_o      (alu1_hint)
  );

  ixu_alu i_alu0 (
    .cpu_clk_i     (cpu_clk_i),
    .reset_i       (reset_i),
    .issue_valid_i (issue0_valid_i),
    .issue_rob_i   (issue0_rob_i),
    .rs1_data_i    (issue0_rs1_i),
    .rs2_data_i    (issue0_rs2_i),
    .ins_type_i    (alu0_ins_type),
    .imm_i         (alu0_imm),
    .immediate_i   (alu0_immediate),
    .dest_i        (alu0_dest),
    .hint_i        (alu0_hint),
    .res_valid_o   (res0_valid),
    .res_data_o    (res0_data),
    .res_dest_o    (res0_dest),
    .res_rob_o     (res0_rob),
    .res_hint_o    (res0_hint)
  );

  ixu_alu i_alu1 (
    .cpu_clk_i     (cpu_clk_i),
    .reset_i       (reset_i),
    .issue_valid_i (issue1_valid_i),
    .issue_rob_i   (issue1_rob_i),
    .rs1_data_i    (issue1_rs1_i),
    .rs2_data_i    (issue1_rs2_i),
    .ins_type_i    (alu1_ins_type),
    .imm_i         (alu1_imm),
    .immediate_i   (alu1_immediate),
    .dest_i        (alu1_dest),
    .hint_i        (alu1_hint),
    .res_valid_o   (res1_valid),
    .res_data_o    (res1_data),
    .res_dest_o    (res1_dest),
    .res_rob_o     (res1_rob),
    .res_hint_o    (res1_hint)
  );

  ixu_wb_merge i_wb_merge (
    .cpu_clk_i    (cpu_clk_i),
    .reset_i      (reset_i),
    .res0_valid_i (res0_valid),
    .res0_data_i  (res0_data),
    .res0_dest_i  (res0_dest),
    .res0_rob_i   (res0_rob),
    .res0_hint_i  (res0_hint),
    .res1_valid_i (res1_valid),
    .res1_data_i  (res1_data),
    .res1_dest_i  (res1_dest),
    .res1_rob_i   (res1_rob),
    .res1_hint_i  (res1_hint),
    .wb_valid_o   (wb_valid_o),
    .wb_data_o    (wb_data_o),
    .wb_dest_o    (wb_dest_o),
    .wb_rob_o     (wb_rob_o),
    .wb_hint_o    (wb_hint_o),
    .stall_o      (stall_o)
  );

endmodule

// ==== source/ixu_wb_merge.sv ====
// Two-lane writeback merger

module ixu_wb_merge (
  input  logic                 cpu_clk_i,
  input  logic                 reset_i,
  // Lane 0 result
  input  logic                 res0_valid_i,
  input  ixu_pkg::xlen_t       res0_data_i,
  input  ixu_pkg::phys_reg_t   res0_dest_i,
  input  ixu_pkg::rob_id_t     res0_rob_i,
  input  ixu_pkg::hint_t       res0_hint_i,
  // Lane 1 result
  input  logic                 res1_valid_i,
  input  ixu_pkg::xlen_t       res1_data_i,
  input  ixu_pkg::phys_reg_t   res1_dest_i,
  input  ixu_pkg::rob_id_t     res1_rob_i,
  input  ixu_pkg::hint_t       res1_hint_i,
  // Single register-file write port
  output logic                 wb_valid_o,
  output ixu_pkg::xlen_t       wb_data_o,
  output ixu_pkg::phys_reg_t   wb_dest_o,
  output ixu_pkg::rob_id_t     wb_rob_o,
  output ixu_pkg::hint_t       wb_hint_o,
  output logic                 stall_o
);

  logic               both_valid;
  logic               hold_valid;
  ixu_pkg::xlen_t     hold_data;
  ixu_pkg::phys_reg_t hold_dest;
  ixu_pkg::rob_id_t   hold_rob;
  ixu_pkg::hint_t     hold_hint;

  assign both_valid = res0_valid_i & res1_valid_i;

  // The issuer sees this in the cycle the hold is loaded and skips issue,
  // which keeps the lanes quiet while the hold drains
  assign stall_o = both_valid;

  // Hold is full for exactly the cycle after a collision
  always_ff @(posedge cpu_clk_i) begin
    if (reset_i) begin
      hold_valid <= 1'b0;
    end else begin
      hold_valid <= both_valid;
    end
  end

  // Lane 1 is parked on a collision
  always_ff @(posedge cpu_clk_i) begin
    if (both_valid) begin
      hold_data <= res1_data_i;
      hold_dest <= res1_dest_i;
      hold_rob  <= res1_rob_i;
      hold_hint <= res1_hint_i;
    end
  end

  // Priority is hold, then lane 0, then lane 1
  always_comb begin
    wb_valid_o = hold_valid | res0_valid_i | res1_valid_i;
    if (hold_valid) begin
      wb_data_o = hold_data;
      wb_dest_o = hold_dest;
      wb_rob_o  = hold_rob;
      wb_hint_o = hold_hint;
    end else if (res0_valid_i) begin
      wb_data_o = res0_data_i;
      wb_dest_o = res0_dest_i;
      wb_rob_o  = res0_rob_i;
      wb_hint_o = res0_hint_i;
    end else begin
      wb_data_o = res1_data_i;
      wb_dest_o = res1_dest_i;
      wb_rob_o  = res1_rob_i;
      wb_hint_o = res1_hint_i;
    end
  end

  // A lane result during a drain would be lost, so the issuer must honour stall
  a_no_result_while_held : assert property (
    @(posedge cpu_clk_i) disable iff (reset_i)
    hold_valid |-> !(res0_valid_i || res1_valid_i)
  );

endmodule
